// File: hdl/g729_pkg.sv
`default_nettype none

package g729_pkg;

	////////////////////////////////////////////////////////////
	// Word widths of the G.729 fixed-point basic operations
	////////////////////////////////////////////////////////////

	// Long word, Word32 in the codec sources
	localparam int WORD_W = 32;

	// Short word, Word16
	localparam int HALF_W = 16;

	// Magnitude at or above this counts as normalized
	localparam logic [WORD_W-1:0] NORM_FACTOR = 32'h4000_0000;

	////////////////////////////////////////////////////////////
	// State encodings
	////////////////////////////////////////////////////////////

	// norm_l sequencer
	typedef enum logic {
		NORM_IDLE,
		NORM_SHIFT
	} norm_state_t;

	// Log2 controller
	typedef enum logic [1:0] {
		L2_IDLE,
		L2_NORM,
		L2_INTERP,
		L2_OUT
	} log2_state_t;

	////////////////////////////////////////////////////////////
	// Log2 table
	////////////////////////////////////////////////////////////

	// 32 intervals plus the closing end point
	localparam int TABLE_SIZE = 33;

endpackage

`default_nettype wire

// File: hdl/norm_l.sv
`default_nettype none

module norm_l
	import g729_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ready,
	input  logic signed [WORD_W-1:0] var1,
	output logic        [HALF_W-1:0] norm,
	output logic                     done
);

	norm_state_t state;
	norm_state_t next_state;

	// Working magnitude, never negative once latched
	logic [WORD_W-1:0] val_q;
	logic [HALF_W-1:0] count_q;

	logic start;
	logic trivial;
	logic at_norm;

	// Zero and minus one have no leading bit to find
	assign trivial = (var1 == '0) || (var1 == {WORD_W{1'b1}});
	assign start = (state == NORM_IDLE) && ready;
	assign at_norm = (val_q >= NORM_FACTOR);

	// Count only shown while a shift run is active
	// Fast path finishes in IDLE, so it reads as 0
	assign norm = (state == NORM_SHIFT) ? count_q : '0;

	////////////////////////////////////////////////////////////
	// Next state and done
	////////////////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		done = 1'b0;
		case (state)
			NORM_IDLE:
			begin
				// Trivial inputs answer in the ready cycle
				if (ready && trivial)
					done = 1'b1;
				else if (ready)
					next_state = NORM_SHIFT;
			end
			NORM_SHIFT:
			begin
				// Bit 30 reached, count is final
				if (at_norm)
				begin
					done = 1'b1;
					next_state = NORM_IDLE;
				end
			end
			default:
				next_state = NORM_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= NORM_IDLE;
		else
			state <= next_state;
	end

	// Shift counter
	always_ff @(posedge clk)
	begin
		if (reset)
			count_q <= '0;
		else if (start)
			count_q <= '0;
		else if ((state == NORM_SHIFT) && !at_norm)
			count_q <= count_q + 1'b1;
	end

	// Magnitude register
	// Negative values take the ones' complement, as in the standard
	always_ff @(posedge clk)
	begin
		if (start)
			val_q <= var1[WORD_W-1] ? ~var1 : var1;
		else if ((state == NORM_SHIFT) && !at_norm)
			val_q <= val_q << 1;
	end

	// A non-trivial input reaches bit 30 within 30 shifts
	norm_range_a: assert property (@(posedge clk) disable iff (reset)
		(state == NORM_SHIFT) |-> (count_q <= 16'd30));

endmodule

`default_nettype wire

// File: hdl/log2_table.sv
`default_nettype none

module log2_table
	import g729_pkg::*;
(
	input  logic [4:0]        index,
	output logic [HALF_W-1:0] tab_lo,
	output logic [HALF_W-1:0] tab_hi
);

	////////////////////////////////////////////////////////////
	// Log2 sample points
	////////////////////////////////////////////////////////////

	// Entry i is 32768 * log2(1 + i/32), rounded, Q15
	// Last entry saturates at 32767
	localparam logic [HALF_W-1:0] LOG2_TAB [0:TABLE_SIZE-1] = '{
		16'd0,
		16'd1455,
		16'd2866,
		16'd4236,
		16'd5568,
		16'd6863,
		16'd8124,
		16'd9352,
		16'd10549,
		16'd11716,
		16'd12855,
		16'd13967,
		16'd15054,
		16'd16117,
		16'd17156,
		16'd18172,
		16'd19167,
		16'd20142,
		16'd21097,
		16'd22033,
		16'd22951,
		16'd23852,
		16'd24735,
		16'd25603,
		16'd26455,
		16'd27291,
		16'd28113,
		16'd28922,
		16'd29716,
		16'd30497,
		16'd31266,
		16'd32023,
		16'd32767
	};

	// Upper neighbour, one bit wider so entry 32 is reachable
	logic [5:0] index_hi;

	assign index_hi = {1'b0, index} + 6'd1;

	// Both ends of the interval in the same cycle
	assign tab_lo = LOG2_TAB[index];
	assign tab_hi = LOG2_TAB[index_hi];

endmodule

`default_nettype wire

// File: hdl/log2_interp.sv
`default_nettype none

module log2_interp
	import g729_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              interp_start,
	input  logic [WORD_W-1:0] norm_x,
	output logic [4:0]        index,
	input  logic [HALF_W-1:0] tab_lo,
	input  logic [HALF_W-1:0] tab_hi,
	output logic [HALF_W-1:0] frac,
	output logic              frac_valid
);

	// Interpolation weight, Q15
	logic [14:0] a;

	// Stage one registers
	logic                     s1_valid;
	logic        [HALF_W-1:0] lo_q;
	logic signed [HALF_W-1:0] diff_q;
	logic        [14:0]       a_q;

	// Stage two arithmetic
	logic signed [WORD_W-1:0] prod;
	logic signed [WORD_W-1:0] acc;

	////////////////////////////////////////////////////////////
	// Stage one: table lookup and weight
	////////////////////////////////////////////////////////////

	// Bit 30 is the leading one, next five bits pick the interval
	assign index = norm_x[29:25];
	assign a = norm_x[24:10];

	always_ff @(posedge clk)
	begin
		if (interp_start)
		begin
			lo_q <= tab_lo;
			// Table rises, so the difference is zero or negative
			diff_q <= $signed(tab_lo) - $signed(tab_hi);
			a_q <= a;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage two: L_msu of the difference and weight
	////////////////////////////////////////////////////////////

	// Weight zero-extended so it multiplies as a positive value
	assign prod = diff_q * $signed({1'b0, a_q});

	// tab_lo in the high half, minus twice the product
	assign acc = $signed({lo_q, 16'h0000}) - (prod <<< 1);

	always_ff @(posedge clk)
	begin
		if (s1_valid)
			frac <= acc[WORD_W-1:HALF_W];
	end

	// Valid bits travel with the data, one item per stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			frac_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= interp_start;
			frac_valid <= s1_valid;
		end
	end

	// Controller must hand over a normalized value
	norm_x_a: assert property (@(posedge clk) disable iff (reset)
		interp_start |-> norm_x[30]);

endmodule

`default_nettype wire

// File: hdl/log2_ctrl.sv
`default_nettype none

module log2_ctrl
	import g729_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ready,
	input  logic signed [WORD_W-1:0] l_x,
	output logic                     norm_ready,
	input  logic        [HALF_W-1:0] norm,
	input  logic                     norm_done,
	output logic                     interp_start,
	output logic        [WORD_W-1:0] norm_x,
	input  logic        [HALF_W-1:0] frac,
	input  logic                     frac_valid,
	output logic                     done,
	output logic                     busy,
	output logic        [HALF_W-1:0] exponent,
	output logic        [HALF_W-1:0] fraction
);

	log2_state_t state;
	log2_state_t next_state;

	// Copy of the input for the shift after norm_l
	logic [WORD_W-1:0] x_q;
	// Exponent waiting for the fraction
	logic [HALF_W-1:0] exp_q;

	logic accept;
	logic positive;

	////////////////////////////////////////////////////////////
	// Handshake with norm_l and the interpolator
	////////////////////////////////////////////////////////////

	// Requests while busy fall through here
	assign accept = (state == L2_IDLE) && ready;
	// Log2 is only defined above zero
	assign positive = (l_x > 32'sd0);

	// norm_l sees l_x directly, so it starts on the same edge
	assign norm_ready = accept && positive;

	// Shift and launch in the norm_done cycle
	assign interp_start = (state == L2_NORM) && norm_done;
	assign norm_x = x_q << norm;

	assign busy = (state != L2_IDLE);

	always_comb
	begin
		next_state = state;
		case (state)
			L2_IDLE:
			begin
				if (accept)
					next_state = positive ? L2_NORM : L2_OUT;
			end
			L2_NORM:
			begin
				if (norm_done)
					next_state = L2_INTERP;
			end
			L2_INTERP:
			begin
				if (frac_valid)
					next_state = L2_OUT;
			end
			// Done cycle, busy still high
			L2_OUT:
				next_state = L2_IDLE;
			default:
				next_state = L2_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= L2_IDLE;
		else
			state <= next_state;
	end

	// Input copy and pending exponent
	always_ff @(posedge clk)
	begin
		if (accept)
			x_q <= l_x;
		if (interp_start)
			exp_q <= HALF_W'(30) - norm;
	end

	////////////////////////////////////////////////////////////
	// Result registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			done <= 1'b0;
			exponent <= '0;
			fraction <= '0;
		end
		else
		begin
			done <= 1'b0;
			// Non-positive fast path
			if (accept && !positive)
			begin
				done <= 1'b1;
				exponent <= '0;
				fraction <= '0;
			end
			else if ((state == L2_INTERP) && frac_valid)
			begin
				done <= 1'b1;
				exponent <= exp_q;
				fraction <= frac;
			end
		end
	end

	// norm_l answers only while the sequencer waits for it
	norm_done_a: assert property (@(posedge clk) disable iff (reset)
		norm_done |-> (state == L2_NORM));

	// Done is a single-cycle pulse
	done_pulse_a: assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

endmodule

`default_nettype wire

// File: hdl/log2_unit.sv
`default_nettype none

module log2_unit
	import g729_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ready,
	input  logic signed [WORD_W-1:0] l_x,
	output logic                     done,
	output logic                     busy,
	output logic        [HALF_W-1:0] exponent,
	output logic        [HALF_W-1:0] fraction
);

	// Controller to normalizer
	logic              norm_ready;
	logic [HALF_W-1:0] norm;
	logic              norm_done;

	// Controller to interpolator
	logic              interp_start;
	logic [WORD_W-1:0] norm_x;
	logic [HALF_W-1:0] frac;
	logic              frac_valid;

	// Interpolator to table
	logic [4:0]        index;
	logic [HALF_W-1:0] tab_lo;
	logic [HALF_W-1:0] tab_hi;

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	log2_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.ready        (ready),
		.l_x          (l_x),
		.norm_ready   (norm_ready),
		.norm         (norm),
		.norm_done    (norm_done),
		.interp_start (interp_start),
		.norm_x       (norm_x),
		.frac         (frac),
		.frac_valid   (frac_valid),
		.done         (done),
		.busy         (busy),
		.exponent     (exponent),
		.fraction     (fraction)
	);

	// Normalizer reads l_x straight from the port
	norm_l u_norm (
		.clk   (clk),
		.reset (reset),
		.ready (norm_ready),
		.var1  (l_x),
		.norm  (norm),
		.done  (norm_done)
	);

	////////////////////////////////////////////////////////////
	// Fraction datapath
	////////////////////////////////////////////////////////////

	log2_interp u_interp (
		.clk          (clk),
		.reset        (reset),
		.interp_start (interp_start),
		.norm_x       (norm_x),
		.index        (index),
		.tab_lo       (tab_lo),
		.tab_hi       (tab_hi),
		.frac         (frac),
		.frac_valid   (frac_valid)
	);

	log2_table u_table (
		.index  (index),
		.tab_lo (tab_lo),
		.tab_hi (tab_hi)
	);

endmodule

`default_nettype wire

// File: verification/tb_log2_unit.sv
`default_nettype none

module tb_log2_unit;

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////
	// Run length and limits
	////////////////////////////////////////////////////////////

	// Operations per test, in test order
	localparam int NUM_NEG = 20;
	localparam int NUM_RANDOM = 500;
	localparam int NUM_SMALL = 100;
	localparam int NUM_OPS = 3 + NUM_NEG + NUM_RANDOM + 33 + NUM_SMALL + 3;

	// Worst case is 30 shifts plus four, so 40 cycles per op is ample
	localparam int CYCLES_PER_OP = 40;
	localparam int WATCHDOG_NS = NUM_OPS * CYCLES_PER_OP * 10 + 2000;
	localparam int DONE_LIMIT = 40;

	logic               clk;
	logic               reset;
	logic               ready;
	logic signed [31:0] l_x;
	logic               done;
	logic               busy;
	logic        [15:0] exponent;
	logic        [15:0] fraction;

	int errors;
	int checks;
	int ops;
	int tests_run;
	int err_mark;
	int op_mark;

	logic [31:0] lfsr_state;

	// Q15 Log2 sample points of the standard
	int ref_table [0:32] = '{
		0, 1455, 2866, 4236, 5568, 6863,
		8124, 9352, 10549, 11716, 12855, 13967,
		15054, 16117, 17156, 18172, 19167, 20142,
		21097, 22033, 22951, 23852, 24735, 25603,
		26455, 27291, 28113, 28922, 29716, 30497,
		31266, 32023, 32767
	};

	log2_unit DUT (
		.clk      (clk),
		.reset    (reset),
		.ready    (ready),
		.l_x      (l_x),
		.done     (done),
		.busy     (busy),
		.exponent (exponent),
		.fraction (fraction)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Random source
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit, bits packed from the LSB end
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference Log2
	////////////////////////////////////////////////////////////

	function automatic void model_log2(
		input  logic signed [31:0] value,
		output logic        [15:0] exp_o,
		output logic        [15:0] frac_o,
		output int                 shifts
	);
		logic [31:0] x;
		int          idx;
		longint      a_w;
		longint      lo;
		longint      hi;
		longint      acc;
		begin
			shifts = 0;
			exp_o = '0;
			frac_o = '0;
			// Non-positive input gives zero for both
			if (value > 0)
			begin
				x = value;
				// Leading one up to bit 30
				while (x < 32'h4000_0000)
				begin
					x = x << 1;
					shifts++;
				end
				exp_o = 16'(30 - shifts);
				// High word after L_shr by 9, less 32
				idx = int'(x >> 25) - 32;
				a_w = longint'((x >> 10) & 32'h0000_7FFF);
				lo = longint'(ref_table[idx]);
				hi = longint'(ref_table[idx + 1]);
				// L_msu, never saturates for this table
				acc = (lo <<< 16) - 2 * (lo - hi) * a_w;
				frac_o = 16'(acc >>> 16);
			end
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////

	task automatic check_idle(input string where);
		begin
			checks++;
			assert (!done && !busy && (exponent == 16'd0) && (fraction == 16'd0))
			else
			begin
				$display("ERR %0t: outputs not idle %s, done=%b busy=%b exp=%h frac=%h",
					$time, where, done, busy, exponent, fraction);
				errors++;
			end
		end
	endtask

	// One ready pulse, wait for done, compare with the model
	task automatic run_op(input logic signed [31:0] value);
		int          latency;
		int          lat_e;
		int          shifts;
		logic [15:0] exp_e;
		logic [15:0] frac_e;
		begin
			model_log2(value, exp_e, frac_e, shifts);
			// Fast path answers next cycle
			lat_e = (value > 0) ? shifts + 4 : 1;
			@(negedge clk);
			ready = 1'b1;
			l_x = value;
			@(posedge clk);
			@(negedge clk);
			ready = 1'b0;
			latency = 1;
			while (!done && (latency < DONE_LIMIT))
			begin
				@(negedge clk);
				latency++;
			end
			ops++;
			if (!done)
			begin
				$display("No done pulse within %0d cycles for input %h", DONE_LIMIT, value);
				errors++;
			end
			else
			begin
				checks += 3;
				assert (exponent == exp_e)
				else
				begin
					$display("ERR %0t: input %h exponent %0d, expected %0d",
						$time, value, exponent, exp_e);
					errors++;
				end
				assert (fraction == frac_e)
				else
				begin
					$display("ERR %0t: input %h fraction %0d, expected %0d",
						$time, value, fraction, frac_e);
					errors++;
				end
				assert (latency == lat_e)
				else
				begin
					$display("ERR %0t: input %h done after %0d cycles, expected %0d",
						$time, value, latency, lat_e);
					errors++;
				end
			end
		end
	endtask

	// Second ready while busy must leave no trace
	task automatic check_ignored_ready();
		logic signed [31:0] first;
		logic        [15:0] exp_e;
		logic        [15:0] frac_e;
		logic        [15:0] got_exp;
		logic        [15:0] got_frac;
		int                 shifts;
		int                 dones;
		begin
			// Long normalization keeps the unit busy
			first = random_bits(31) >> 24;
			if (first == 0)
				first = 1;
			model_log2(first, exp_e, frac_e, shifts);
			got_exp = '0;
			got_frac = '0;
			dones = 0;
			@(negedge clk);
			ready = 1'b1;
			l_x = first;
			@(posedge clk);
			@(negedge clk);
			ready = 1'b0;
			@(negedge clk);
			checks++;
			assert (busy)
			else
			begin
				$display("ERR %0t: busy low while input %h was still in progress",
					$time, first);
				errors++;
			end
			ready = 1'b1;
			l_x = 32'sh7000_0000;
			@(negedge clk);
			ready = 1'b0;
			repeat (60)
			begin
				if (done)
				begin
					dones++;
					got_exp = exponent;
					got_frac = fraction;
				end
				@(negedge clk);
			end
			ops++;
			checks += 3;
			assert (dones == 1)
			else
			begin
				$display("ERR %0t: %0d done pulses, expected 1", $time, dones);
				errors++;
			end
			assert ((got_exp == exp_e) && (got_frac == frac_e))
			else
			begin
				$display("ERR %0t: input %h gave exp %0d frac %0d, expected %0d %0d",
					$time, first, got_exp, got_frac, exp_e, frac_e);
				errors++;
			end
			assert (!busy)
			else
			begin
				$display("ERR %0t: busy still high after the window", $time);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input string name);
		begin
			$display("Test %0s: %0d ops, %0d errors", name, ops - op_mark, errors - err_mark);
			tests_run++;
			op_mark = ops;
			err_mark = errors;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic        [31:0] r;
		logic signed [31:0] v;
		int                 sh;
		clk = 1'b0;
		reset = 1'b1;
		ready = 1'b0;
		l_x = '0;
		errors = 0;
		checks = 0;
		ops = 0;
		tests_run = 0;
		err_mark = 0;
		op_mark = 0;
		lfsr_state = 32'd92;

		// Outputs settle on the first reset edge
		repeat (4)
		begin
			@(posedge clk);
			@(negedge clk);
			check_idle("during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle("after reset");
		finish_test("reset");

		// Zero, minus one, most negative, then random negatives
		run_op(32'sd0);
		run_op(-32'sd1);
		run_op(32'sh8000_0000);
		repeat (NUM_NEG)
		begin
			r = random_bits(31);
			run_op(r | 32'h8000_0000);
		end
		finish_test("non-positive");

		repeat (NUM_RANDOM)
		begin
			r = random_bits(31);
			if (r == 0)
				r = 1;
			run_op(r);
		end
		finish_test("random positive");

		// Powers of two land on table entry 0
		for (int k = 0; k < 31; k++)
		begin
			v = 32'h1 << k;
			run_op(v);
			checks++;
			assert ((exponent == 16'(k)) && (fraction == 16'd0))
			else
			begin
				$display("ERR %0t: 2^%0d gave exp %0d frac %0d", $time, k, exponent, fraction);
				errors++;
			end
		end
		run_op(32'sh7FFF_FFFF);
		run_op(32'sd1);
		finish_test("edge values");

		// Short values need many shifts
		repeat (NUM_SMALL)
		begin
			r = random_bits(31);
			sh = int'(random_bits(5)) % 31;
			v = r >> sh;
			if (v == 0)
				v = 1;
			run_op(v);
		end
		finish_test("small positive");

		check_ignored_ready();
		finish_test("ready while busy");

		$display("Summary: %0d tests, %0d ops, %0d checks, %0d errors",
			tests_run, ops, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hdl/g729_pkg.sv
hdl/norm_l.sv
hdl/log2_table.sv
hdl/log2_interp.sv
hdl/log2_ctrl.sv
hdl/log2_unit.sv
verification/tb_log2_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Log2 unit testbench with Verilator
set -e

cd "$(dirname "$0")"

# Binary build with timing support for the testbench delays
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_log2_unit \
	-f sim.f

# Capture the output even when the simulation exits with an error
status=0
output=$(./obj_dir/Vtb_log2_unit 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation did not pass, exit status $status"
exit 1
